// ==== verilog.f ====
+incdir+hdl
hdl/smc_pkg.sv
hdl/smc_access_ctrl.sv
hdl/smc_byte_lane.sv
hdl/smc_read_merge.sv
hdl/smc_mac_top.sv
bench/smc_mac_checker.sv
bench/tb_smc_mac.sv

// ==== Makefile ====
# Verilator build and run of the multiple access block testbench

TOP  := tb_smc_mac
SRCS := $(shell grep -v '^+' verilog.f) hdl/smc_consts.svh

.PHONY: all run clean

all: run

# rebuilt only when the file list or a source changes
obj_dir/V$(TOP): verilog.f $(SRCS)
	verilator --binary -j 0 -f verilog.f --top-module $(TOP)

# pass only when the pass line shows up in the output
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== bench/smc_mac_vectors.txt ====
// we xfer_size bus_size wb_dat_w chunk0 chunk1 chunk2 chunk3 exp_rd (hex, size 0=8 1=16 2=32)
// chunks in access order: memory data on reads, expected ext_data_out on writes
1 0 0 A1B2C3D4 000000D4 00000000 00000000 00000000 00000000
1 0 1 A1B2C3D4 000000D4 00000000 00000000 00000000 00000000
1 0 2 A1B2C3D4 000000D4 00000000 00000000 00000000 00000000
1 1 0 A1B2C3D4 000000C3 000000D4 00000000 00000000 00000000
1 1 1 A1B2C3D4 0000C3D4 00000000 00000000 00000000 00000000
1 1 2 A1B2C3D4 0000C3D4 00000000 00000000 00000000 00000000
1 2 0 A1B2C3D4 000000A1 000000B2 000000C3 000000D4 00000000
1 2 1 A1B2C3D4 0000A1B2 0000C3D4 00000000 00000000 00000000
1 2 2 A1B2C3D4 A1B2C3D4 00000000 00000000 00000000 00000000
1 3 1 A1B2C3D4 0000A1B2 0000C3D4 00000000 00000000 00000000
0 0 0 5A5A5A5A EEEEEE5A 00000000 00000000 00000000 5A5A5A5A
0 0 1 5A5A5A5A EEEE773C 00000000 00000000 00000000 3C3C3C3C
0 0 2 5A5A5A5A 11223396 00000000 00000000 00000000 96969696
0 1 0 5A5A5A5A EEEEEE12 EEEEEE34 00000000 00000000 12341234
0 1 1 5A5A5A5A EEEEBEEF 00000000 00000000 00000000 BEEFBEEF
0 1 2 5A5A5A5A 9988CAFE 00000000 00000000 00000000 CAFECAFE
0 2 0 5A5A5A5A EEEEEE01 EEEEEE23 EEEEEE45 EEEEEE67 01234567
0 2 1 5A5A5A5A EEEE89AB EEEECDEF 00000000 00000000 89ABCDEF
0 2 2 5A5A5A5A FEDCBA98 00000000 00000000 00000000 FEDCBA98
0 1 3 5A5A5A5A EEEE5566 00000000 00000000 00000000 55665566
FFFFFFFF

// ==== bench/tb_smc_mac.sv ====
/*
  Testbench for the multiple access block. Reads one transfer per line from
  the vector file, acts as Wishbone master and as external memory with
  random ext_done delays, and leaves the comparing to the checker module.
*/

`timescale 1ns/1ns
`default_nettype none

`include "smc_consts.svh"

module tb_smc_mac
  import smc_pkg::*;
();

  localparam int FIELDS  = 9;          // words per vector line
  localparam int MAX_VEC = 64;
  localparam int CYC_PER_VEC = 4 * 5 + 4;

  logic                          sys_clk9;
  logic                          n_sys_reset9;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [`SMC_DATA_W-1:0]        wb_dat_w;
  logic [`SMC_DATA_W-1:0]        wb_dat_r;
  logic                          wb_ack;
  xfer_size_t                    xfer_size;
  xfer_size_t                    bus_size;
  logic                          ext_strobe;
  logic                          ext_we;
  logic [`SMC_DATA_W-1:0]        ext_data_out;
  logic [`SMC_DATA_W-1:0]        ext_data_in;
  logic                          ext_done;
  // expected values of the running transfer
  int                            test_num;
  logic [3:0][`SMC_DATA_W-1:0]   exp_chunks;
  logic [`SMC_DATA_W-1:0]        exp_rd;
  logic                          all_done;
  int                            err_count;
  int                            tests_done;
  logic                          summary_done;

  logic [31:0] vec_mem [0:MAX_VEC*FIELDS-1];
  int          nvec;
  int          seed;
  int          cycle_cnt;
  int          cycle_limit = MAX_VEC * CYC_PER_VEC + 58;   // until the file is read

  smc_mac_top smc_mac_top_i
  (
    .sys_clk9     (sys_clk9),
    .n_sys_reset9 (n_sys_reset9),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .xfer_size    (xfer_size),
    .bus_size     (bus_size),
    .ext_strobe   (ext_strobe),
    .ext_we       (ext_we),
    .ext_data_out (ext_data_out),
    .ext_data_in  (ext_data_in),
    .ext_done     (ext_done)
  );

  smc_mac_checker u_check
  (
    .sys_clk9     (sys_clk9),
    .n_sys_reset9 (n_sys_reset9),
    .wb_ack       (wb_ack),
    .wb_dat_r     (wb_dat_r),
    .ext_strobe   (ext_strobe),
    .ext_we       (ext_we),
    .ext_data_out (ext_data_out),
    .ext_done     (ext_done),
    .test_num     (test_num),
    .exp_we       (wb_we),
    .exp_xfer     (xfer_size),
    .exp_bus      (bus_size),
    .exp_chunks   (exp_chunks),
    .exp_rd       (exp_rd),
    .all_done     (all_done),
    .err_count    (err_count),
    .tests_done   (tests_done),
    .summary_done (summary_done)
  );

  initial
  begin
    sys_clk9 = 1'b0;
    forever #50 sys_clk9 = ~sys_clk9;   // 100 ns period
  end

  // watchdog, limit scaled to the number of vectors
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge sys_clk9);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, transfer %0d never finished", cycle_cnt, test_num);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic load_vectors();
    nvec = 0;
    $readmemh("bench/smc_mac_vectors.txt", vec_mem);
    while (nvec < MAX_VEC && vec_mem[nvec*FIELDS] !== 32'hffff_ffff)
      nvec++;                                   // stop at end marker
    cycle_limit = nvec * CYC_PER_VEC + 8 + 50;
  endtask

  //--------------------------------------------------------------------------
  // memory model, one ext_done per access while the strobe is up
  //--------------------------------------------------------------------------
  task automatic serve_accesses();
    int k;
    int delay;
    k = 0;
    while (!ext_strobe)
      @(negedge sys_clk9);
    while (ext_strobe && k < 8)                 // cap in case of runaway strobe
    begin
      delay = $unsigned($random(seed)) % 4;     // 0..3 wait cycles
      repeat (delay) @(negedge sys_clk9);
      ext_data_in = exp_chunks[k[1:0]];
      ext_done    = 1'b1;
      @(negedge sys_clk9);
      ext_done    = 1'b0;
      ext_data_in = $random(seed);              // junk between accesses
      k++;
    end
  endtask

  task automatic run_transfer(input int v);
    int base;
    base       = v * FIELDS;
    test_num   = v;
    wb_we      = vec_mem[base][0];
    xfer_size  = xfer_size_t'(vec_mem[base+1][1:0]);
    bus_size   = xfer_size_t'(vec_mem[base+2][1:0]);
    wb_dat_w   = vec_mem[base+3];
    exp_chunks = {vec_mem[base+7], vec_mem[base+6], vec_mem[base+5], vec_mem[base+4]};
    exp_rd     = vec_mem[base+8];
    wb_cyc     = 1'b1;
    wb_stb     = 1'b1;
    serve_accesses();
    while (!wb_ack)
      @(negedge sys_clk9);
    wb_cyc = 1'b0;                              // held until ack
    wb_stb = 1'b0;
    @(negedge sys_clk9);
  endtask

  initial
  begin
    seed = 32'hd9f2_a25d;
    n_sys_reset9 = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_dat_w = '0;
    xfer_size = SIZE_8;
    bus_size = SIZE_8;
    ext_data_in = '0;
    ext_done = 1'b0;
    test_num = 0;
    exp_chunks = '0;
    exp_rd = '0;
    all_done = 1'b0;
    load_vectors();
    if (nvec == 0 || nvec == MAX_VEC)
    begin
      $display("vector file is missing, empty or has no end marker");
      $display("STATUS: FAIL");
    end
    else
    begin
      repeat (8) @(negedge sys_clk9);
      n_sys_reset9 = 1'b1;
      @(negedge sys_clk9);
      for (int v = 0; v < nvec; v++)
        run_transfer(v);
      repeat (2) @(negedge sys_clk9);
      all_done = 1'b1;
      wait (summary_done);
      if (err_count == 0 && tests_done == nvec)
        $display("STATUS: PASS");
      else
      begin
        if (tests_done != nvec)
          $display("only %0d of %0d transfers were acknowledged", tests_done, nvec);
        $display("STATUS: FAIL");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/smc_mac_checker.sv ====
/*
  Checker for the multiple access block testbench. Samples the DUT ports on
  the rising clock edge, compares access count, write chunks, read data and
  handshake timing against the current vector, prints a line per transfer.
*/

`timescale 1ns/1ns
`default_nettype none

`include "smc_consts.svh"

module smc_mac_checker
  import smc_pkg::*;
(
  input  wire logic                         sys_clk9,
  input  wire logic                         n_sys_reset9,
  // DUT ports under watch
  input  wire logic                         wb_ack,
  input  wire logic [`SMC_DATA_W-1:0]       wb_dat_r,
  input  wire logic                         ext_strobe,
  input  wire logic                         ext_we,
  input  wire logic [`SMC_DATA_W-1:0]       ext_data_out,
  input  wire logic                         ext_done,
  // current vector
  input  int                                test_num,
  input  wire logic                         exp_we,
  input  xfer_size_t                        exp_xfer,
  input  xfer_size_t                        exp_bus,
  input  wire logic [3:0][`SMC_DATA_W-1:0]  exp_chunks,   // per access
  input  wire logic [`SMC_DATA_W-1:0]       exp_rd,
  input  wire logic                         all_done,
  output int                                err_count,
  output int                                tests_done,
  output logic                              summary_done
);

  int   errs = 0;
  int   tests = 0;
  int   passed = 0;
  int   done_cnt = 0;      // ext_done pulses this transfer
  int   test_errs = 0;
  logic prev_ack = 1'b0;
  logic prev_strobe = 1'b0;
  logic prev_done = 1'b0;
  logic shown = 1'b0;
  logic [`SMC_DATA_W-1:0] prev_data = '0;

  assign err_count    = errs;
  assign tests_done   = tests;
  assign summary_done = shown;

  function automatic int byte_count(input xfer_size_t code);
    case (code)
      SIZE_8:  return 1;
      SIZE_16: return 2;
      default: return 4;   // 32 and reserved
    endcase
  endfunction

  // N = max(1, T/B)
  function automatic int access_count(input xfer_size_t xfer, input xfer_size_t bus);
    int t;
    int b;
    t = byte_count(xfer);
    b = byte_count(bus);
    return (t > b) ? t / b : 1;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("mismatch at time %0t: test %0d, %s", $time, test_num, msg);
    test_errs++;
    errs++;
  endtask

  task automatic report_error(input string msg);
    $display("error at time %0t in test %0d: %s", $time, test_num, msg);
    test_errs++;
    errs++;
  endtask

  //--------------------------------------------------------------------------
  // end of transfer checks on the edge that closes the ack cycle
  //--------------------------------------------------------------------------
  task automatic close_test();
    int n_exp;
    n_exp = access_count(exp_xfer, exp_bus);
    if (done_cnt != n_exp)
      report_mismatch($sformatf("%0d accesses, expected %0d", done_cnt, n_exp));
    if (!(prev_done && prev_strobe))
      report_error("wb_ack did not come one cycle after the last ext_done");
    if (ext_strobe)
      report_error("ext_strobe still high in the ack cycle");
    if (!exp_we && wb_dat_r !== exp_rd)
      report_mismatch($sformatf("wb_dat_r %h, expected %h", wb_dat_r, exp_rd));
    if (test_errs == 0)
    begin
      passed++;
      $display("test %0d ok: %s of %0d bits on %0d-bit bus, %0d accesses", test_num,
               exp_we ? "write" : "read", byte_count(exp_xfer) * 8,
               byte_count(exp_bus) * 8, done_cnt);
    end
    else
      $display("test %0d failed with %0d errors", test_num, test_errs);
    tests++;
    test_errs = 0;
    done_cnt  = 0;
  endtask

  always @(posedge sys_clk9)
  begin
    if (!n_sys_reset9)
    begin
      if (wb_ack !== 1'b0 || ext_strobe !== 1'b0 || ext_we !== 1'b0)
        report_error("wb_ack, ext_strobe or ext_we not low in reset");
      done_cnt = 0;
      prev_ack = 1'b0;
      prev_strobe = 1'b0;
      prev_done = 1'b0;
    end
    else
    begin
      // bus must hold while the memory is still busy
      if (prev_strobe && !prev_done && !ext_strobe)
        report_error("ext_strobe dropped before the memory signalled ext_done");
      if (prev_strobe && !prev_done && ext_strobe && ext_data_out !== prev_data)
        report_mismatch($sformatf("ext_data_out moved from %h to %h before ext_done",
                                  prev_data, ext_data_out));
      if (ext_strobe && ext_we !== exp_we)
        report_mismatch($sformatf("ext_we %b, expected %b", ext_we, exp_we));
      if (ext_done && ext_strobe)
      begin
        if (exp_we && done_cnt < 4 && ext_data_out !== exp_chunks[done_cnt[1:0]])
          report_mismatch($sformatf("access %0d ext_data_out %h, expected %h", done_cnt,
                                    ext_data_out, exp_chunks[done_cnt[1:0]]));
        done_cnt++;
      end
      if (wb_ack && prev_ack)
        report_error("wb_ack held high for more than one cycle");
      else if (wb_ack)
        close_test();
      prev_ack    = wb_ack;
      prev_strobe = ext_strobe;
      prev_done   = ext_done;
      prev_data   = ext_data_out;
    end
  end

  always @(posedge all_done)
  begin
    $display("%0d tests run, %0d passed, %0d errors", tests, passed, errs);
    shown = 1'b1;
  end

endmodule

`default_nettype wire

// ==== hdl/smc_mac_top.sv ====
/*
  Multiple access block top level. Wishbone classic slave on the host side,
  8/16/32-bit static memory bus on the other. Sequencer, four byte lanes
  and the read merge stage, wired together here.
*/

`timescale 1ns/1ns
`default_nettype none

`include "smc_consts.svh"

module smc_mac_top
  import smc_pkg::*;
(
  input  wire logic                   sys_clk9,
  input  wire logic                   n_sys_reset9,
  // wishbone slave
  input  wire logic                   wb_cyc,
  input  wire logic                   wb_stb,
  input  wire logic                   wb_we,
  input  wire logic [`SMC_DATA_W-1:0] wb_dat_w,
  output logic [`SMC_DATA_W-1:0]      wb_dat_r,
  output logic                        wb_ack,
  input  xfer_size_t                  xfer_size,   // tag, held with stb
  input  xfer_size_t                  bus_size,    // width strap
  // external memory bus
  output logic                        ext_strobe,
  output logic                        ext_we,
  output logic [`SMC_DATA_W-1:0]      ext_data_out,
  input  wire logic [`SMC_DATA_W-1:0] ext_data_in,
  input  wire logic                   ext_done
);

  logic        capture;
  access_idx_t access_idx;
  xfer_size_t  xfer_size_q;
  xfer_size_t  bus_size_q;

  logic [`SMC_LANES-1:0][`SMC_BYTE_W-1:0] rd_lanes;   // captured read bytes
  logic [`SMC_LANES-1:0][`SMC_BYTE_W-1:0] wr_lanes;   // external write lanes

  //--------------------------------------------------------------------------
  // sequencer
  //--------------------------------------------------------------------------
  smc_access_ctrl u_ctrl
  (
    .sys_clk9     (sys_clk9),
    .n_sys_reset9 (n_sys_reset9),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .xfer_size    (xfer_size),
    .bus_size     (bus_size),
    .wb_ack       (wb_ack),
    .ext_done     (ext_done),
    .ext_strobe   (ext_strobe),
    .ext_we       (ext_we),
    .capture      (capture),
    .access_idx   (access_idx),
    .xfer_size_q  (xfer_size_q),
    .bus_size_q   (bus_size_q)
  );

  //--------------------------------------------------------------------------
  // byte lanes
  //--------------------------------------------------------------------------
  for (genvar g = 0; g < `SMC_LANES; g++)
  begin : g_lane
    smc_byte_lane #(.LANE(g)) u_lane
    (
      .sys_clk9     (sys_clk9),
      .n_sys_reset9 (n_sys_reset9),
      .capture      (capture),
      .access_idx   (access_idx),
      .xfer_size_q  (xfer_size_q),
      .bus_size_q   (bus_size_q),
      .ext_data_in  (ext_data_in),
      .wb_dat_w     (wb_dat_w),
      .rd_byte      (rd_lanes[g]),
      .wr_byte      (wr_lanes[g])
    );
  end

  assign ext_data_out = wr_lanes;   // lane g drives external byte g

  //--------------------------------------------------------------------------
  // read data to host
  //--------------------------------------------------------------------------
  smc_read_merge u_merge
  (
    .lane_bytes  (rd_lanes),
    .xfer_size_q (xfer_size_q),
    .wb_dat_r    (wb_dat_r)
  );

endmodule

`default_nettype wire

// ==== hdl/smc_read_merge.sv ====
/*
  Read merge. Takes the low bytes of the assembled lane word that belong
  to the transfer and repeats them across the 32-bit host read data.
  Purely combinational, valid in the ack cycle.
*/

`timescale 1ns/1ns
`default_nettype none

`include "smc_consts.svh"

module smc_read_merge
  import smc_pkg::*;
(
  input  wire logic [`SMC_LANES-1:0][`SMC_BYTE_W-1:0] lane_bytes,
  input  xfer_size_t                                  xfer_size_q,
  output logic [`SMC_DATA_W-1:0]                      wb_dat_r
);

  logic [2:0] t_bytes;   // bytes in transfer
  logic [1:0] t_mask;    // byte index modulo transfer size

  assign t_bytes = 3'd1 << size_lg(xfer_size_q);
  assign t_mask  = 2'(t_bytes - 3'd1);

  //--------------------------------------------------------------------------
  // replication
  //   8 bit  -> b0 b0 b0 b0
  //   16 bit -> b1 b0 b1 b0
  //   32 bit -> b3 b2 b1 b0
  //--------------------------------------------------------------------------
  always_comb
  begin
    for (int k = 0; k < `SMC_LANES; k++)
    begin
      wb_dat_r[k*`SMC_BYTE_W +: `SMC_BYTE_W] = lane_bytes[2'(k) & t_mask];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/smc_byte_lane.sv ====
/*
  One byte lane of the host word. Captures its read byte from the right
  external lane on the right access, and drives its external lane with the
  selected host write byte, or zero when the lane is unused.
*/

`timescale 1ns/1ns
`default_nettype none

`include "smc_consts.svh"

module smc_byte_lane
  import smc_pkg::*;
#(
  parameter int unsigned LANE = 0     // host byte and external lane number
)
(
  input  wire logic                   sys_clk9,
  input  wire logic                   n_sys_reset9,
  input  wire logic                   capture,
  input  access_idx_t                 access_idx,
  input  xfer_size_t                  xfer_size_q,
  input  xfer_size_t                  bus_size_q,
  input  wire logic [`SMC_DATA_W-1:0] ext_data_in,
  input  wire logic [`SMC_DATA_W-1:0] wb_dat_w,
  output logic [`SMC_BYTE_W-1:0]      rd_byte,    // assembled host byte
  output logic [`SMC_BYTE_W-1:0]      wr_byte     // onto external lane LANE
);

  localparam logic [2:0] LANE_NUM = 3'(LANE);

  logic [1:0]  lg_b;
  logic [2:0]  t_bytes;     // bytes in transfer
  logic [2:0]  b_bytes;     // bytes on bus
  logic [1:0]  b_mask;      // lane index modulo bus width
  logic [1:0]  src_lane;    // external lane feeding this byte
  access_idx_t cap_idx;     // access on which this byte arrives
  logic        hit;
  logic [3:0]  host_idx;    // host byte wanted on our external lane

  assign lg_b    = size_lg(bus_size_q);
  assign t_bytes = 3'd1 << size_lg(xfer_size_q);
  assign b_bytes = 3'd1 << lg_b;
  assign b_mask  = 2'(b_bytes - 3'd1);

  //--------------------------------------------------------------------------
  // read capture
  //--------------------------------------------------------------------------
  assign src_lane = LANE_NUM[1:0] & b_mask;
  assign cap_idx  = access_idx_t'(LANE_NUM >> lg_b);
  assign hit = capture && (LANE_NUM < t_bytes) && (access_idx == cap_idx);

  always_ff @(posedge sys_clk9 or negedge n_sys_reset9)
  begin
    if (!n_sys_reset9)
      rd_byte <= '0;
    else if (hit)
      rd_byte <= ext_data_in[src_lane*`SMC_BYTE_W +: `SMC_BYTE_W];
  end

  //--------------------------------------------------------------------------
  // write select
  //--------------------------------------------------------------------------
  // high chunk first: counter counts down from the top
  assign host_idx = ({2'b00, access_idx} << lg_b) | {1'b0, LANE_NUM};

  always_comb
  begin
    wr_byte = '0;                            // unused lanes stay zero
    if ((LANE_NUM < b_bytes) && (host_idx < {1'b0, t_bytes}))
      wr_byte = wb_dat_w[host_idx[1:0]*`SMC_BYTE_W +: `SMC_BYTE_W];
  end

endmodule

`default_nettype wire

// ==== hdl/smc_access_ctrl.sv ====
/*
  Wishbone classic slave and access sequencer. Latches the host request,
  runs one to four external accesses, one per ext_done, then acks.
  Counter and latched sizes steer the byte lanes.
*/

`timescale 1ns/1ns
`default_nettype none

`include "smc_consts.svh"

module smc_access_ctrl
  import smc_pkg::*;
(
  input  wire logic  sys_clk9,
  input  wire logic  n_sys_reset9,
  // host side
  input  wire logic  wb_cyc,
  input  wire logic  wb_stb,
  input  wire logic  wb_we,
  input  xfer_size_t xfer_size,     // host transfer size
  input  xfer_size_t bus_size,      // external width strap
  output logic       wb_ack,
  // memory side
  input  wire logic  ext_done,
  output logic       ext_strobe,
  output logic       ext_we,
  // lane steering
  output logic       capture,       // read data valid this edge
  output access_idx_t access_idx,
  output xfer_size_t xfer_size_q,
  output xfer_size_t bus_size_q
);

  ctrl_state_t state;
  logic        we_q;                 // direction of current transfer
  logic [1:0]  lg_t;                 // log2 transfer bytes
  logic [1:0]  lg_b;                 // log2 bus bytes
  logic [1:0]  lg_n;                 // log2 access count
  logic [2:0]  num_acc;              // accesses needed, 1..4
  access_idx_t first_idx;

  //--------------------------------------------------------------------------
  // access count from the incoming sizes
  //--------------------------------------------------------------------------
  assign lg_t = size_lg(xfer_size);
  assign lg_b = size_lg(bus_size);
  // narrow transfer on wide bus still needs one access
  assign lg_n = (lg_t > lg_b) ? (lg_t - lg_b) : 2'd0;
  assign num_acc = 3'd1 << lg_n;
  assign first_idx = access_idx_t'(num_acc - 3'd1);  // count down to zero

  //--------------------------------------------------------------------------
  // sequencer
  //--------------------------------------------------------------------------
  always_ff @(posedge sys_clk9 or negedge n_sys_reset9)
  begin
    if (!n_sys_reset9)
    begin
      state       <= ST_IDLE;
      access_idx  <= '0;
      xfer_size_q <= SIZE_8;
      bus_size_q  <= SIZE_8;
      we_q        <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (wb_cyc && wb_stb)        // new request
          begin
            state       <= ST_ACCESS;
            xfer_size_q <= xfer_size;
            bus_size_q  <= bus_size;
            we_q        <= wb_we;
            access_idx  <= first_idx;
          end
        end
        ST_ACCESS:
        begin
          if (ext_done)              // memory holds us here until done
          begin
            if (access_idx == '0)
              state <= ST_ACK;       // last access finished
            else
              access_idx <= access_idx - 1'b1;
          end
        end
        default:                     // ack cycle, stb ignored
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // outputs, decoded from registered state
  //--------------------------------------------------------------------------
  assign ext_strobe = (state == ST_ACCESS);   // high over all accesses
  assign ext_we     = ext_strobe & we_q;
  assign wb_ack     = (state == ST_ACK);      // single cycle pulse

  // only a read access in progress loads the lanes
  assign capture = ext_done & ext_strobe & ~we_q;

endmodule

`default_nettype wire

// ==== hdl/smc_pkg.sv ====
/*
  Shared types for the multiple access block: size codes, access
  counter and sequencer states. Import with smc_pkg::* in the module header.
*/

`default_nettype none

`include "smc_consts.svh"

package smc_pkg;

  // size code, used for both transfer size and bus width strap
  typedef enum logic [1:0]
  {
    SIZE_8   = 2'd0,
    SIZE_16  = 2'd1,
    SIZE_32  = 2'd2,
    SIZE_RSV = 2'd3   // reserved, handled as 32
  } xfer_size_t;

  typedef logic [`SMC_CNT_W-1:0] access_idx_t;  // accesses left

  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_ACCESS,
    ST_ACK
  } ctrl_state_t;

  // log2 of the byte count for a size code
  function automatic logic [1:0] size_lg(input xfer_size_t size);
    case (size)
      SIZE_8:  return 2'd0;
      SIZE_16: return 2'd1;
      default: return 2'd2;   // 32 and reserved
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== hdl/smc_consts.svh ====
/*
  Width constants for the static memory controller access block.
  Include this wherever bus, lane or counter widths are needed.
*/

`ifndef SMC_CONSTS_SVH
`define SMC_CONSTS_SVH

// host and external data width
`define SMC_DATA_W 32
// byte lanes on the host word
`define SMC_LANES 4
`define SMC_BYTE_W 8   // one lane
// accesses remaining, up to 4 per transfer
`define SMC_CNT_W 2

`endif
